//--- verilog/tape_pkg.sv
// tape player shared definitions
// TAP image constants, state encodings and the bundles passed between blocks
`default_nettype none

package tape_pkg;

	// ------------------------------------------------------------------------
	// TAP image and playback constants
	// ------------------------------------------------------------------------

	// io-controller index of a TAP download
	localparam logic [7:0] TAP_INDEX = 8'h41;
	// 4k byte tape memory
	localparam int TAP_ADDR_W = 12;
	// pulse data starts after the 20 byte header
	localparam int TAP_HDR_LEN = 20;
	localparam int TAP_VER_OFFS = 12;
	// buffer depth, also the credit pool of the fetcher
	localparam int FIFO_DEPTH = 8;
	localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);
	// clocks per TAP length unit
	localparam int TICK_DIV = 8;
	// units of a v0 zero byte
	localparam int LONG_PULSE = 256;
	localparam int PULSE_W = 24;

	typedef enum logic [1:0] {
		TAP_V0 = 2'd0,
		TAP_V1 = 2'd1
	} tap_version_e;

	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_EXT0,
		DEC_EXT1,
		DEC_EXT2,
		DEC_LOW,
		DEC_HIGH
	} dec_state_e;

	// byte stream from the io-controller, data_io style
	typedef struct packed {
		logic                  downloading;
		logic [7:0]            index;
		logic                  wr;
		logic [TAP_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} ioctl_t;

	typedef struct packed {
		logic                  en;
		logic [TAP_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} ram_wr_t;

	// what the player needs to know about the stored image
	typedef struct packed {
		tap_version_e          version;
		logic [TAP_ADDR_W-1:0] end_addr;
	} tap_info_t;

endpackage

`default_nettype wire

//--- verilog/tap_loader.sv
// TAP download loader
// picks TAP downloads out of the io-controller stream, writes them into
// tape memory and keeps the image version and end pointer
`default_nettype none

module tap_loader import tape_pkg::*; (
	input  wire logic      clk28,
	input  wire logic      reset,
	input  wire ioctl_t    ioctl_i,
	output ram_wr_t        ram_wr_o,
	output tap_info_t      info_o,
	output logic           restart_o
);

	logic tap_dl;
	logic tap_dl_q;
	logic tap_wr;

	// only index 0x41 is a tape image, everything else passes by
	assign tap_dl = ioctl_i.downloading && (ioctl_i.index == TAP_INDEX);
	assign tap_wr = tap_dl && ioctl_i.wr;

	// hold the player in restart for the whole download plus one cycle,
	// which covers the last memory write
	assign restart_o = tap_dl | tap_dl_q;

	// ------------------------------------------------------------------------
	// memory write port
	// ------------------------------------------------------------------------

	always_ff @(posedge clk28) begin
		if (reset) begin
			ram_wr_o.en <= 1'b0;
		end else begin
			ram_wr_o.en <= tap_wr;
		end
		// stream address is the memory address
		ram_wr_o.addr <= ioctl_i.addr;
		ram_wr_o.data <= ioctl_i.data;
	end

	// ------------------------------------------------------------------------
	// image info
	// ------------------------------------------------------------------------

	always_ff @(posedge clk28) begin
		if (reset) begin
			tap_dl_q <= 1'b0;
			info_o.version <= TAP_V0;
			info_o.end_addr <= '0;
		end else begin
			tap_dl_q <= tap_dl;
			if (tap_wr) begin
				// end pointer is one past the last byte written
				info_o.end_addr <= ioctl_i.addr + 1'b1;
				if (ioctl_i.addr == TAP_ADDR_W'(TAP_VER_OFFS)) begin
					info_o.version <= ioctl_i.data[0] ? TAP_V1 : TAP_V0;
				end
			end else if (tap_dl && !tap_dl_q) begin
				// new image, forget the old length
				info_o.end_addr <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/tape_ram.sv
// tape image memory
// byte wide, one write port from the loader and one registered read port
`default_nettype none

module tape_ram import tape_pkg::*; (
	input  wire logic                  clk28,
	input  wire ram_wr_t               wr_i,
	input  wire logic                  rd_en_i,
	input  wire logic [TAP_ADDR_W-1:0] rd_addr_i,
	output logic [7:0]                 rd_data_o
);

	logic [7:0] mem [0:(1 << TAP_ADDR_W)-1];

	// write side, loader only
	always_ff @(posedge clk28) begin
		if (wr_i.en) begin
			mem[wr_i.addr] <= wr_i.data;
		end
	end

	// read side, data one cycle after rd_en
	always_ff @(posedge clk28) begin
		if (rd_en_i) begin
			rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

`default_nettype wire

//--- verilog/tap_fetcher.sv
// tape byte fetcher
// walks the stored image from the end of the header and pushes each byte
// into the buffer, one read per credit
`default_nettype none

module tap_fetcher import tape_pkg::*; (
	input  wire logic          clk28,
	input  wire logic          reset,
	input  wire logic          restart_i,
	input  wire tap_info_t     info_i,
	output logic               rd_en_o,
	output logic [TAP_ADDR_W-1:0] rd_addr_o,
	input  wire logic [7:0]    rd_data_i,
	output logic               push_o,
	output logic [7:0]         push_data_o,
	input  wire logic          credit_i
);

	logic [TAP_ADDR_W-1:0] addr_q;
	logic [CREDIT_W-1:0]   credits_q;
	logic                  push_q;
	logic                  can_read;

	// a read needs a free slot, counting reads still on their way
	assign can_read = !restart_i && (addr_q < info_i.end_addr) && (credits_q != '0);

	assign rd_en_o = can_read;
	assign rd_addr_o = addr_q;

	// memory data arrives the cycle after the read, push it straight on
	assign push_o = push_q;
	assign push_data_o = rd_data_i;

	always_ff @(posedge clk28) begin
		if (reset || restart_i) begin
			addr_q <= TAP_ADDR_W'(TAP_HDR_LEN);
			credits_q <= CREDIT_W'(FIFO_DEPTH);
			push_q <= 1'b0;
		end else begin
			push_q <= can_read;
			if (can_read) begin
				addr_q <= addr_q + 1'b1;
			end
			// spend one per read, get one back per byte consumed
			credits_q <= credits_q - CREDIT_W'(can_read) + CREDIT_W'(credit_i);
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// buffer never returns more credits than were spent
	a_credit_max: assert property (@(posedge clk28) disable iff (reset || restart_i)
		credits_q <= CREDIT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- verilog/tap_fifo.sv
// tape byte buffer
// small ring between fetcher and pulse generator, gives one credit back
// for each byte the pulse generator takes
`default_nettype none

module tap_fifo import tape_pkg::*; (
	input  wire logic       clk28,
	input  wire logic       reset,
	input  wire logic       restart_i,
	input  wire logic       push_i,
	input  wire logic [7:0] push_data_i,
	output logic            head_valid_o,
	output logic [7:0]      head_data_o,
	input  wire logic       take_i,
	output logic            credit_o
);

	logic [7:0] mem [0:FIFO_DEPTH-1];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
	logic [CREDIT_W-1:0] count_q;

	assign head_valid_o = (count_q != '0);
	assign head_data_o = mem[rd_ptr_q];

	// storage, no flush needed since count says what is valid
	always_ff @(posedge clk28) begin
		if (push_i) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge clk28) begin
		if (reset || restart_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (take_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + CREDIT_W'(push_i) - CREDIT_W'(take_i);
			// slot freed, tell the fetcher
			credit_o <= take_i;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// the fetcher's credit count must keep it from overrunning the ring
	a_no_push_full: assert property (@(posedge clk28) disable iff (reset || restart_i)
		push_i |-> (count_q < CREDIT_W'(FIFO_DEPTH)));

	// the pulse generator only takes what is there
	a_no_take_empty: assert property (@(posedge clk28) disable iff (reset || restart_i)
		take_i |-> head_valid_o);

endmodule

`default_nettype wire

//--- verilog/tape_pulse_gen.sv
// cassette pulse generator
// turns TAP values into one low/high wave each on the cassette read line,
// handles the v1 three byte lengths and the play/stop toggle
`default_nettype none

module tape_pulse_gen import tape_pkg::*; (
	input  wire logic         clk28,
	input  wire logic         reset,
	input  wire logic         restart_i,
	input  wire tap_version_e version_i,
	input  wire logic         play_toggle_i,
	input  wire logic         head_valid_i,
	input  wire logic [7:0]   head_data_i,
	output logic              take_o,
	output logic              cass_read_o,
	output logic              motor_o
);

	dec_state_e state_q;
	logic [PULSE_W-1:0] len_q;
	logic [PULSE_W-1:0] cnt_q;
	logic [PULSE_W-1:0] new_len;
	logic [PULSE_W-1:0] high_len;
	logic playing_q;

	assign motor_o = playing_q;
	// line idles high, only the low phase pulls it down
	assign cass_read_o = (state_q != DEC_LOW);
	// high phase gets whatever the low half left over
	assign high_len = len_q - (len_q >> 1);

	// ------------------------------------------------------------------------
	// byte take
	// ------------------------------------------------------------------------

	always_comb begin
		take_o = 1'b0;
		if (!restart_i) begin
			case (state_q)
				// new pulse only while playing
				DEC_IDLE: take_o = playing_q && head_valid_i;
				// extension bytes belong to a pulse already started
				DEC_EXT0, DEC_EXT1, DEC_EXT2: take_o = head_valid_i;
				default: take_o = 1'b0;
			endcase
		end
	end

	// length that the current take completes
	always_comb begin
		new_len = len_q;
		case (state_q)
			DEC_IDLE: begin
				if (head_data_i == 8'd0) begin
					new_len = PULSE_W'(LONG_PULSE * TICK_DIV);
				end else begin
					new_len = PULSE_W'(head_data_i) * PULSE_W'(TICK_DIV);
				end
			end
			// top byte of the little endian length
			DEC_EXT2: new_len = {head_data_i, len_q[15:0]};
			default: new_len = len_q;
		endcase
	end

	// ------------------------------------------------------------------------
	// decode and pulse timing FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge clk28) begin
		if (reset || restart_i) begin
			state_q <= DEC_IDLE;
			playing_q <= 1'b0;
		end else begin
			if (play_toggle_i) begin
				playing_q <= !playing_q;
			end
			case (state_q)
				DEC_IDLE: begin
					if (take_o) begin
						if (head_data_i == 8'd0 && version_i == TAP_V1) begin
							state_q <= DEC_EXT0;
						end else begin
							state_q <= DEC_LOW;
						end
					end
				end
				DEC_EXT0: if (take_o) state_q <= DEC_EXT1;
				DEC_EXT1: if (take_o) state_q <= DEC_EXT2;
				DEC_EXT2: if (take_o) state_q <= DEC_LOW;
				DEC_LOW: begin
					// idle cycle is the last high cycle, skip HIGH if that is all
					if (cnt_q <= 1) begin
						state_q <= (high_len > 1) ? DEC_HIGH : DEC_IDLE;
					end
				end
				DEC_HIGH: if (cnt_q <= 1) state_q <= DEC_IDLE;
				default: state_q <= DEC_IDLE;
			endcase
		end
	end

	// length and phase counter, payload only
	always_ff @(posedge clk28) begin
		case (state_q)
			DEC_EXT0: if (take_o) len_q[7:0] <= head_data_i;
			DEC_EXT1: if (take_o) len_q[15:8] <= head_data_i;
			DEC_LOW: begin
				if (cnt_q <= 1) begin
					cnt_q <= high_len - 1'b1;
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
			DEC_HIGH: cnt_q <= cnt_q - 1'b1;
			default: ;
		endcase
		// last byte of a pulse, load the low half
		if ((state_q == DEC_IDLE || state_q == DEC_EXT2) && take_o) begin
			len_q <= new_len;
			cnt_q <= new_len >> 1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tape_player.sv
// cassette tape player
// TAP download into tape memory, credit based fetch through a small
// buffer and pulse generation on the cassette read line
`default_nettype none

module tape_player import tape_pkg::*; (
	input  wire logic   clk28,
	input  wire logic   reset,
	input  wire ioctl_t ioctl_i,
	input  wire logic   play_toggle_i,
	output logic        cass_read_o,
	output logic        motor_o
);

	ram_wr_t ram_wr;
	tap_info_t info;
	logic restart;
	logic rd_en;
	logic [TAP_ADDR_W-1:0] rd_addr;
	logic [7:0] rd_data;
	logic push;
	logic [7:0] push_data;
	logic credit;
	logic head_valid;
	logic [7:0] head_data;
	logic take;

	// ------------------------------------------------------------------------
	// download side
	// ------------------------------------------------------------------------

	tap_loader tap_loader_inst (
		.clk28     (clk28),
		.reset     (reset),
		.ioctl_i   (ioctl_i),
		.ram_wr_o  (ram_wr),
		.info_o    (info),
		.restart_o (restart)
	);

	tape_ram tape_ram_inst (
		.clk28     (clk28),
		.wr_i      (ram_wr),
		.rd_en_i   (rd_en),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	// ------------------------------------------------------------------------
	// playback side
	// ------------------------------------------------------------------------

	tap_fetcher tap_fetcher_inst (
		.clk28       (clk28),
		.reset       (reset),
		.restart_i   (restart),
		.info_i      (info),
		.rd_en_o     (rd_en),
		.rd_addr_o   (rd_addr),
		.rd_data_i   (rd_data),
		.push_o      (push),
		.push_data_o (push_data),
		.credit_i    (credit)
	);

	tap_fifo tap_fifo_inst (
		.clk28        (clk28),
		.reset        (reset),
		.restart_i    (restart),
		.push_i       (push),
		.push_data_i  (push_data),
		.head_valid_o (head_valid),
		.head_data_o  (head_data),
		.take_i       (take),
		.credit_o     (credit)
	);

	tape_pulse_gen tape_pulse_gen_inst (
		.clk28         (clk28),
		.reset         (reset),
		.restart_i     (restart),
		.version_i     (info.version),
		.play_toggle_i (play_toggle_i),
		.head_valid_i  (head_valid),
		.head_data_i   (head_data),
		.take_o        (take),
		.cass_read_o   (cass_read_o),
		.motor_o       (motor_o)
	);

endmodule

`default_nettype wire

//--- tb/tb_tape_player.sv
// tape player testbench
// random TAP images from an xorshift source, downloaded and played back,
// low phase lengths checked against a model of the TAP decoding rules
`default_nettype none

module tb_tape_player import tape_pkg::*; ();

	localparam int NTAPES = 5;
	localparam int MAX_BYTES = 512;
	localparam int MAX_VALS = 64;
	// longer than any high phase plus fetch latency
	localparam int IDLE_WIN = 1100;

	logic clk28;
	logic reset;
	ioctl_t ioctl;
	logic play_toggle;
	logic cass_read;
	logic motor;

	// tape images and their expected low phases
	logic [7:0] image [NTAPES][MAX_BYTES];
	int image_len [NTAPES];
	int exp_low [NTAPES][MAX_VALS];
	int exp_cnt [NTAPES];
	int len_sum [NTAPES];

	int got_low [$];
	int low_run;
	logic [31:0] rng;
	int errors;
	int checks;
	int tests;
	int test_err0;
	string cur_test;
	int cycle_cnt;
	int cycle_limit;
	int paused_n;
	int paused_lows;

	tape_player tape_player_inst (
		.clk28         (clk28),
		.reset         (reset),
		.ioctl_i       (ioctl),
		.play_toggle_i (play_toggle),
		.cass_read_o   (cass_read),
		.motor_o       (motor)
	);

	always #5 clk28 = ~clk28;

	// ------------------------------------------------------------------------
	// monitor and watchdog
	// ------------------------------------------------------------------------

	// measure each low phase on the cassette line, sampled mid cycle
	always @(negedge clk28) begin
		if (reset) begin
			low_run = 0;
		end else if (!cass_read) begin
			low_run = low_run + 1;
		end else if (low_run > 0) begin
			got_low.push_back(low_run);
			low_run = 0;
		end
	end

	always @(posedge clk28) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function int rand_below(input int n);
		rng = xorshift32(rng);
		return int'(rng % 32'(n));
	endfunction

	// header, then values; a zero under v1 carries a 3 byte cycle count
	task build_tape(input int t, input tap_version_e ver, input int nvals);
		int a;
		int v;
		int len;
		string magic;
		magic = "C64-TAPE-RAW";
		for (int i = 0; i < TAP_HDR_LEN; i++) image[t][i] = 8'h00;
		for (int i = 0; i < 12; i++) image[t][i] = magic[i];
		image[t][TAP_VER_OFFS] = (ver == TAP_V1) ? 8'd1 : 8'd0;
		a = TAP_HDR_LEN;
		len_sum[t] = 0;
		for (int i = 0; i < nvals; i++) begin
			// value 2 is always a zero so every tape has one
			if (i == 2 || rand_below(8) == 0) begin
				image[t][a] = 8'd0;
				a = a + 1;
				if (ver == TAP_V1) begin
					len = 16 + rand_below(385);
					image[t][a] = 8'(len);
					image[t][a + 1] = 8'(len >> 8);
					image[t][a + 2] = 8'd0;
					a = a + 3;
				end else begin
					len = LONG_PULSE * TICK_DIV;
				end
			end else begin
				v = 1 + rand_below(60);
				image[t][a] = 8'(v);
				a = a + 1;
				len = v * TICK_DIV;
			end
			exp_low[t][i] = len / 2;
			len_sum[t] = len_sum[t] + len;
		end
		// data length field, little endian
		image[t][16] = 8'(a - TAP_HDR_LEN);
		image[t][17] = 8'((a - TAP_HDR_LEN) >> 8);
		exp_cnt[t] = nvals;
		image_len[t] = a;
	endtask

	task fill_junk(input int t, input int n);
		for (int a = 0; a < n; a++) image[t][a] = 8'(rand_below(256));
		image_len[t] = n;
		exp_cnt[t] = 0;
		len_sum[t] = 0;
	endtask

	task step;
		@(posedge clk28);
		#1;
	endtask

	// data_io style, one wr pulse every other cycle
	task download(input int t, input logic [7:0] index);
		for (int a = 0; a < image_len[t]; a++) begin
			step();
			ioctl.downloading = 1'b1;
			ioctl.index = index;
			ioctl.wr = 1'b1;
			ioctl.addr = TAP_ADDR_W'(a);
			ioctl.data = image[t][a];
			step();
			ioctl.wr = 1'b0;
		end
		step();
		ioctl.downloading = 1'b0;
		ioctl.index = 8'h00;
		repeat (3) step();
	endtask

	task toggle_play;
		play_toggle = 1'b1;
		step();
		play_toggle = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------------

	task check_value(input string what, input int expected, input int actual);
		checks = checks + 1;
		if (expected != actual) begin
			errors = errors + 1;
			$display("mismatch in %s, %s: expected %0d, actual %0d",
				cur_test, what, expected, actual);
		end
	endtask

	task start_test(input string name);
		cur_test = name;
		test_err0 = errors;
	endtask

	task end_test;
		tests = tests + 1;
		$display("test %s finished with %0d errors", cur_test, errors - test_err0);
	endtask

	task wait_pulses(input int n);
		while (got_low.size() < n) step();
	endtask

	// whole tape played, then a quiet window to catch extra pulses
	task play_through(input int t);
		wait_pulses(exp_cnt[t]);
		repeat (IDLE_WIN) step();
		check_value("pulse in progress at end", 0, low_run);
		check_value("pulse count", exp_cnt[t], got_low.size());
		for (int i = 0; i < exp_cnt[t] && i < got_low.size(); i++) begin
			check_value($sformatf("low phase %0d", i), exp_low[t][i], got_low[i]);
		end
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		clk28 = 1'b0;
		reset = 1'b1;
		ioctl = '0;
		play_toggle = 1'b0;
		low_run = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		cycle_cnt = 0;
		rng = 32'd32219;

		build_tape(0, TAP_V0, 40);
		build_tape(1, TAP_V1, 40);
		build_tape(2, TAP_V0, 30);
		build_tape(3, TAP_V1, 24);
		fill_junk(4, 120);

		// plays: A, B, C, B partly, D twice; downloads: A B C B D junk D junk
		cycle_limit = 2 * (len_sum[0] + 2 * len_sum[1] + len_sum[2] + 2 * len_sum[3]);
		cycle_limit = cycle_limit + 2 * (image_len[0] + 2 * image_len[1] + image_len[2]);
		cycle_limit = cycle_limit + 2 * (2 * image_len[3] + 2 * image_len[4]) + 8 * 4;
		cycle_limit = cycle_limit + 6 * IDLE_WIN + 100;

		repeat (4) @(posedge clk28);
		#1;
		reset = 1'b0;
		step();

		start_test("v0 playback");
		download(0, TAP_INDEX);
		got_low.delete();
		toggle_play();
		check_value("motor on", 1, int'(motor));
		play_through(0);
		end_test();

		start_test("v1 extended lengths");
		download(1, TAP_INDEX);
		got_low.delete();
		toggle_play();
		play_through(1);
		end_test();

		start_test("pause and resume");
		download(2, TAP_INDEX);
		got_low.delete();
		toggle_play();
		wait_pulses(exp_cnt[2] / 2);
		toggle_play();
		check_value("motor off after pause", 0, int'(motor));
		// a take on the toggle edge still finishes its pulse
		step();
		while (!cass_read) step();
		step();
		paused_n = got_low.size();
		paused_lows = 0;
		repeat (IDLE_WIN) begin
			step();
			if (!cass_read) paused_lows = paused_lows + 1;
		end
		check_value("low cycles while paused", 0, paused_lows);
		check_value("pulses while paused", paused_n, got_low.size());
		toggle_play();
		play_through(2);
		end_test();

		start_test("download during playback");
		download(1, TAP_INDEX);
		got_low.delete();
		toggle_play();
		wait_pulses(exp_cnt[1] / 2);
		download(3, TAP_INDEX);
		check_value("motor off after new download", 0, int'(motor));
		check_value("line high after new download", 1, int'(cass_read));
		got_low.delete();
		toggle_play();
		play_through(3);
		end_test();

		start_test("foreign download");
		got_low.delete();
		download(4, 8'h01);
		// no restart, so the player is still running on an empty tape
		check_value("motor during foreign download", 1, int'(motor));
		check_value("pulses during foreign download", 0, got_low.size());
		download(3, TAP_INDEX);
		// stored image has to survive a foreign download before the replay
		download(4, 8'h01);
		got_low.delete();
		toggle_play();
		play_through(3);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
verilog/tape_pkg.sv
verilog/tap_loader.sv
verilog/tape_ram.sv
verilog/tap_fetcher.sv
verilog/tap_fifo.sv
verilog/tape_pulse_gen.sv
verilog/tape_player.sv
tb/tb_tape_player.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tape player testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f \
	--top-module tb_tape_player -o tb_tape_player; then
	echo "verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/tb_tape_player); then
	echo "$sim_out"
	echo "simulation exited with an error status"
	exit 1
fi
echo "$sim_out"

if grep -qx "Simulation finished: PASS" <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
